// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_lcd_spi
RTL_TOP   ?= lcd_spi_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/lcd_testdata.txt ====
// First word holds the host write count and each write follows as {rs, data}
// Next word holds the frame count and each expected frame follows as {rs, rw, data}
008
080 // DDRAM address of line 1
148 // H
169 // i
001 // Clear display
0C0 // DDRAM address of line 2
14F // O
14B // K
002 // Return home
00F // Seven init frames and eight host frames
030 // Wake
030
030
038 // Function set
00C // Display on
001 // Clear
006 // Entry mode
080
248
269
001
0C0
24F
24B
002

// ==== bench/tb_lcd_spi.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module tb_lcd_spi
    import spi_pkg::*;
    import lcd_pkg::*;
();

    localparam int FRAME_CYC = 12 * `LCD_CLK_DIV; // cs_n low time

    logic       clk;
    logic       rst_n;
    logic       host_req;
    logic       host_rs;
    logic [7:0] host_data;
    logic       host_ack;
    logic       ready;
    logic       sdo;
    logic       sclk;
    logic       cs_n;

    logic [11:0] testdata [0:63];
    logic [8:0]  host_writes [0:31];
    spi_frame_t  exp_frames [0:31];
    int          num_writes;
    int          num_frames;
    int          mismatch_errors;
    int          bitcount_errors;
    int          other_errors;
    int          cycle_cnt;
    int          cycle_limit;
    integer      seed;

    // Serial monitor state
    int                      frames_seen;
    int                      low_cnt;
    int                      high_cnt;
    int                      bits_in;
    logic [`LCD_FRAME_W-1:0] shift_in;
    spi_frame_t              last_frame;
    logic                    cs_n_prev;
    logic                    sclk_prev;

    lcd_spi_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .host_req  (host_req),
        .host_rs   (host_rs),
        .host_data (host_data),
        .host_ack  (host_ack),
        .ready     (ready),
        .sdo       (sdo),
        .sclk      (sclk),
        .cs_n      (cs_n)
    );

    always #5 clk = ~clk;

    task automatic check_frame(spi_frame_t got, spi_frame_t exp, string what);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch at %0t: %s got rs=%b rw=%b data=%h, expected rs=%b rw=%b data=%h",
                     $time, what, got.rs, got.rw, got.data, exp.rs, exp.rw, exp.data);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            mismatch_errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) begin
            mismatch_errors++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_gap(int got, int min_cyc, string what);
        if (got < min_cyc) begin
            mismatch_errors++;
            $display("mismatch at %0t: %s is %0d cycles, at least %0d expected",
                     $time, what, got, min_cyc);
        end
    endtask

    // Clear and home need the long settling time
    function automatic int min_gap(spi_frame_t f);
        if (!f.rs && (f.data == LCD_CLEAR || f.data == LCD_HOME)) begin
            return `LCD_LONG_GAP_CYC;
        end
        return `LCD_GAP_CYC;
    endfunction

    task automatic load_testdata();
        int k;
        $readmemh("bench/lcd_testdata.txt", testdata);
        num_writes = int'(testdata[0]);
        for (k = 0; k < num_writes; k++) begin
            host_writes[k] = testdata[1 + k][8:0];
        end
        num_frames = int'(testdata[1 + num_writes]);
        for (k = 0; k < num_frames; k++) begin
            exp_frames[k] = testdata[2 + num_writes + k][9:0];
        end
        if (num_frames != LCD_INIT_LEN + num_writes) begin
            other_errors++;
            $display("test data lists %0d frames for %0d host writes", num_frames, num_writes);
        end
    endtask

    task automatic close_frame();
        spi_frame_t got;
        got        = shift_in;
        last_frame = got;
        if (bits_in != `LCD_FRAME_W) begin
            bitcount_errors++;
            $display("frame %0d ending at %0t carried %0d bits instead of %0d",
                     frames_seen, $time, bits_in, `LCD_FRAME_W);
        end
        check_count(low_cnt, FRAME_CYC, $sformatf("cs_n low time of frame %0d", frames_seen));
        check_bit(got.rw, 1'b0, "rw bit");
        check_bit(ready, frames_seen >= LCD_INIT_LEN, "ready at frame end");
        if (frames_seen < num_frames) begin
            check_frame(got, exp_frames[frames_seen], $sformatf("frame %0d", frames_seen));
        end else begin
            other_errors++;
            $display("unexpected extra frame %0d at %0t", frames_seen, $time);
        end
        frames_seen++;
    endtask

    // Samples on the falling clock edge where every DUT output is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (!ready && host_ack) begin
                check_bit(host_ack, 1'b0, "host_ack before ready");
            end
            if (cs_n_prev && !cs_n) begin
                if (frames_seen > 0) begin
                    check_gap(high_cnt, min_gap(last_frame), "gap before next frame");
                end
                check_bit(ready, frames_seen >= LCD_INIT_LEN, "ready at frame start");
                low_cnt  = 0;
                bits_in  = 0;
                shift_in = '0;
            end
            if (!cs_n) begin
                low_cnt++;
                if (sclk && !sclk_prev) begin // Slave samples here
                    shift_in = {shift_in[`LCD_FRAME_W-2:0], sdo};
                    bits_in++;
                end
            end else begin
                if (!cs_n_prev) begin
                    close_frame();
                    high_cnt = 0;
                end
                high_cnt++;
            end
        end
        cs_n_prev = cs_n;
        sclk_prev = sclk;
    end

    task automatic send_write(int idx);
        int         delay;
        spi_frame_t want;
        want.rs   = host_writes[idx][8];
        want.rw   = 1'b0;
        want.data = host_writes[idx][7:0];
        delay     = $unsigned($random(seed)) % 8;
        repeat (delay) @(negedge clk);
        host_rs   = want.rs;
        host_data = want.data;
        host_req  = 1'b1;
        if (idx == 0) begin
            check_bit(ready, 1'b0, "ready at first host request"); // Request waits for init
        end
        @(negedge clk);
        while (!host_ack) @(negedge clk);
        // This write's frame must already be closed
        check_count(frames_seen, LCD_INIT_LEN + idx + 1, "frames closed at host_ack");
        check_frame(last_frame, want, $sformatf("host write %0d", idx));
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            @(negedge clk);
            check_bit(host_ack, 1'b1, "host_ack while req high");
        end
        host_req = 1'b0;
        @(negedge clk);
        while (host_ack) @(negedge clk);
    endtask

    task automatic report_and_finish();
        $display("errors: %0d mismatch, %0d bit count, %0d other",
                 mismatch_errors, bitcount_errors, other_errors);
        if (mismatch_errors + bitcount_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            other_errors++;
            $display("timeout after %0d cycles with %0d of %0d frames seen",
                     cycle_cnt, frames_seen, num_frames);
            report_and_finish();
        end
    end

    initial begin
        int i;
        $timeformat(-9, 0, " ns", 0);
        seed      = 32'h4a87faa3;
        clk       = 1'b0;
        rst_n     = 1'b0;
        host_req  = 1'b0;
        host_rs   = 1'b0;
        host_data = 8'h00;
        cs_n_prev = 1'b1;
        sclk_prev = 1'b1;
        load_testdata();
        cycle_limit = `LCD_POWERUP_CYC + 8 + 500
                    + num_frames * (FRAME_CYC + 2 + `LCD_LONG_GAP_CYC + 32);
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_bit(cs_n, 1'b1, "cs_n in reset");
        check_bit(sclk, 1'b1, "sclk in reset");
        check_bit(sdo, 1'b0, "sdo in reset");
        check_bit(host_ack, 1'b0, "host_ack in reset");
        check_bit(ready, 1'b0, "ready in reset");
        rst_n = 1'b1;
        for (i = 0; i < num_writes; i++) begin
            send_write(i);
        end
        repeat (`LCD_LONG_GAP_CYC) @(negedge clk); // Room for any stray frame
        check_count(frames_seen, num_frames, "total frames");
        report_and_finish();
    end

endmodule

// ==== compile.f ====
+incdir+design
design/spi_pkg.sv
design/lcd_pkg.sv
design/lcd_spi_shifter.sv
design/lcd_init_sequencer.sv
design/lcd_frame_scheduler.sv
design/lcd_spi_top.sv
bench/tb_lcd_spi.sv

// ==== design/lcd_frame_scheduler.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_frame_scheduler
    import spi_pkg::*;
    import lcd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       init_req,
    input  lcd_instr_t init_data,
    input  logic       ready,
    input  logic       host_req,
    input  logic       host_rs,
    input  logic [7:0] host_data,
    output logic       init_ack,
    output logic       host_ack,
    output logic       start,
    output spi_frame_t frame,
    input  logic       busy,
    input  logic       done
);

    localparam int GAP_W = $clog2(`LCD_LONG_GAP_CYC + 1);

    localparam logic [GAP_W-1:0] SHORT_GAP = GAP_W'(`LCD_GAP_CYC);
    localparam logic [GAP_W-1:0] LONG_GAP  = GAP_W'(`LCD_LONG_GAP_CYC);

    typedef enum logic [1:0] {
        SCH_IDLE = 2'd0,
        SCH_SEND = 2'd1, // Frame on the wire
        SCH_HOLD = 2'd2  // ack high until the owner drops req
    } sched_state_t;

    sched_state_t     state_q;
    logic [GAP_W-1:0] gap_q;
    logic             start_q;
    logic             ack_q;
    logic             host_sel_q; // Link that owns the current frame
    spi_frame_t       frame_q;
    spi_frame_t       next_frame;
    logic             link_req;
    logic             owner_req;
    logic             accept;
    logic             long_gap;

    // Init link only until ready, host only afterwards
    assign link_req  = ready ? host_req : init_req;
    assign owner_req = host_sel_q ? host_req : init_req;
    assign accept    = (state_q == SCH_IDLE) && link_req && !busy && (gap_q == '0);

    always_comb begin
        next_frame.rs   = ready ? host_rs : 1'b0;
        next_frame.rw   = 1'b0;
        next_frame.data = ready ? host_data : init_data;
    end

    assign long_gap = !frame_q.rs && (frame_q.data == LCD_CLEAR || frame_q.data == LCD_HOME);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= SCH_IDLE;
            gap_q      <= '0;
            start_q    <= 1'b0;
            ack_q      <= 1'b0;
            host_sel_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (gap_q != '0) begin
                gap_q <= gap_q - 1'b1;
            end
            case (state_q)
                SCH_IDLE: begin
                    if (accept) begin
                        start_q    <= 1'b1;
                        host_sel_q <= ready;
                        state_q    <= SCH_SEND;
                    end
                end
                SCH_SEND: begin
                    if (done) begin
                        ack_q   <= 1'b1;
                        gap_q   <= long_gap ? LONG_GAP : SHORT_GAP; // Gap counts from done
                        state_q <= SCH_HOLD;
                    end
                end
                SCH_HOLD: begin
                    if (!owner_req) begin
                        ack_q   <= 1'b0;
                        state_q <= SCH_IDLE;
                    end
                end
                default: begin
                    state_q <= SCH_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            frame_q <= next_frame;
        end
    end

    assign start    = start_q;
    assign frame    = frame_q;
    assign init_ack = ack_q && !host_sel_q;
    assign host_ack = ack_q && host_sel_q;

endmodule

// ==== design/lcd_init_sequencer.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_init_sequencer
    import lcd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    output logic       init_req,
    output lcd_instr_t init_data,
    input  logic       init_ack,
    output logic       ready
);

    localparam int PWR_W = $clog2(`LCD_POWERUP_CYC);

    localparam logic [PWR_W-1:0] PWR_LAST  = PWR_W'(`LCD_POWERUP_CYC - 1);
    localparam lcd_step_t        STEP_LAST = lcd_step_t'(LCD_INIT_LEN - 1);

    typedef enum logic [1:0] {
        SEQ_POWERUP = 2'd0,
        SEQ_OFFER   = 2'd1, // req high, waiting for ack
        SEQ_RELEASE = 2'd2, // req low, waiting for ack to drop
        SEQ_DONE    = 2'd3
    } seq_state_t;

    seq_state_t       state_q;
    logic [PWR_W-1:0] pwr_q;
    lcd_step_t        step_q;
    logic             req_q;
    logic             ready_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= SEQ_POWERUP;
            pwr_q   <= '0;
            step_q  <= '0;
            req_q   <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            case (state_q)
                SEQ_POWERUP: begin
                    if (pwr_q == PWR_LAST) begin
                        req_q   <= 1'b1;
                        state_q <= SEQ_OFFER;
                    end else begin
                        pwr_q <= pwr_q + 1'b1;
                    end
                end
                SEQ_OFFER: begin
                    if (init_ack) begin
                        req_q   <= 1'b0;
                        state_q <= SEQ_RELEASE;
                    end
                end
                SEQ_RELEASE: begin
                    if (!init_ack) begin
                        if (step_q == STEP_LAST) begin
                            ready_q <= 1'b1;
                            state_q <= SEQ_DONE;
                        end else begin
                            // Next step offered straight away
                            step_q  <= step_q + 1'b1;
                            req_q   <= 1'b1;
                            state_q <= SEQ_OFFER;
                        end
                    end
                end
                SEQ_DONE: begin
                    state_q <= SEQ_DONE; // Stays here until reset
                end
                default: begin
                    state_q <= SEQ_POWERUP;
                end
            endcase
        end
    end

    assign init_req  = req_q;
    assign init_data = lcd_init_instr(step_q);
    assign ready     = ready_q;

endmodule

// ==== design/lcd_params.svh ====
`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

// RS, RW and 8 data bits
`define LCD_FRAME_W 10

// System clocks per sclk period, must be even
`define LCD_CLK_DIV 4

// Power-up wait before the first init frame
`define LCD_POWERUP_CYC 200

// Settling gaps, since the busy flag cannot be read
`define LCD_GAP_CYC 40
`define LCD_LONG_GAP_CYC 400 // Clear display and return home

`endif

// ==== design/lcd_pkg.sv ====
package lcd_pkg;

    // HD44780 instruction codes in 8-bit mode
    typedef enum logic [7:0] {
        LCD_CLEAR        = 8'h01,
        LCD_HOME         = 8'h02,
        LCD_ENTRY_MODE   = 8'h06, // Increment, no shift
        LCD_DISPLAY_ON   = 8'h0C, // Cursor and blink off
        LCD_WAKE         = 8'h30,
        LCD_FUNCTION_SET = 8'h38  // 8-bit bus, 2 lines, 5x8 font
    } lcd_instr_t;

    localparam int LCD_INIT_LEN = 7;

    typedef logic [$clog2(LCD_INIT_LEN)-1:0] lcd_step_t;

    // Fixed power-up list, three wake-ups first
    function automatic lcd_instr_t lcd_init_instr(lcd_step_t step);
        case (step)
            0, 1, 2: return LCD_WAKE;
            3:       return LCD_FUNCTION_SET;
            4:       return LCD_DISPLAY_ON;
            5:       return LCD_CLEAR;
            default: return LCD_ENTRY_MODE;
        endcase
    endfunction

endpackage

// ==== design/lcd_spi_shifter.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_spi_shifter
    import spi_pkg::*;
#(
    parameter int CLK_DIV = `LCD_CLK_DIV
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,  // One-cycle pulse seen only in idle
    input  spi_frame_t frame,
    output logic       sdo,
    output logic       sclk,
    output logic       cs_n,
    output logic       busy,
    output logic       done
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int BIT_W = $clog2(`LCD_FRAME_W);

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);
    localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(CLK_DIV / 2);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`LCD_FRAME_W - 1);

    spi_state_t              state_q, state_d;
    logic [DIV_W-1:0]        div_q, div_d;   // Position inside one sclk period
    logic [BIT_W-1:0]        bit_q, bit_d;
    logic [`LCD_FRAME_W-1:0] shreg_q, shreg_d;
    logic                    done_q;
    logic                    period_end;

    assign period_end = (div_q == DIV_LAST);

    always_comb begin
        state_d = state_q;
        div_d   = div_q;
        bit_d   = bit_q;
        shreg_d = shreg_q;

        case (state_q)
            SPI_IDLE: begin
                div_d = '0;
                bit_d = '0;
                if (start) begin
                    shreg_d = frame;
                    state_d = SPI_LEAD;
                end
            end
            SPI_LEAD: begin
                div_d = period_end ? '0 : div_q + 1'b1;
                if (period_end) begin
                    state_d = SPI_SHIFT;
                end
            end
            SPI_SHIFT: begin
                div_d = period_end ? '0 : div_q + 1'b1;
                // Next bit goes out as sclk falls again
                if (period_end) begin
                    shreg_d = {shreg_q[`LCD_FRAME_W-2:0], 1'b0};
                    if (bit_q == BIT_LAST) begin
                        state_d = SPI_TRAIL;
                    end else begin
                        bit_d = bit_q + 1'b1;
                    end
                end
            end
            SPI_TRAIL: begin
                div_d = period_end ? '0 : div_q + 1'b1;
                if (period_end) begin
                    state_d = SPI_FINISH;
                end
            end
            SPI_FINISH: begin
                state_d = SPI_IDLE; // cs_n already high here
            end
            default: begin
                state_d = SPI_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= SPI_IDLE;
            div_q   <= '0;
            bit_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            div_q   <= div_d;
            bit_q   <= bit_d;
            done_q  <= (state_q == SPI_FINISH);
        end
    end

    // MSB of the shift register drives sdo
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shreg_q <= '0;
        end else begin
            shreg_q <= shreg_d;
        end
    end

    // Low for the first half of each period and rising in the middle
    assign sclk = (state_q == SPI_SHIFT) ? (div_q >= DIV_HALF) : 1'b1;

    assign sdo  = shreg_q[`LCD_FRAME_W-1];
    assign cs_n = !(state_q == SPI_LEAD || state_q == SPI_SHIFT || state_q == SPI_TRAIL);
    assign busy = (state_q != SPI_IDLE);
    assign done = done_q; // One cycle after cs_n rises

endmodule

// ==== design/lcd_spi_top.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_spi_top
    import spi_pkg::*;
    import lcd_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       host_req,
    input  logic       host_rs,
    input  logic [7:0] host_data,
    output logic       host_ack,
    output logic       ready,
    output logic       sdo,
    output logic       sclk,
    output logic       cs_n
);

    logic       init_req;
    logic       init_ack;
    lcd_instr_t init_data;
    logic       start;
    spi_frame_t frame;
    logic       busy;
    logic       done;

    lcd_init_sequencer u_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_req  (init_req),
        .init_data (init_data),
        .init_ack  (init_ack),
        .ready     (ready)
    );

    lcd_frame_scheduler u_sched (
        .clk       (clk),
        .rst_n     (rst_n),
        .init_req  (init_req),
        .init_data (init_data),
        .ready     (ready),
        .host_req  (host_req),
        .host_rs   (host_rs),
        .host_data (host_data),
        .init_ack  (init_ack),
        .host_ack  (host_ack),
        .start     (start),
        .frame     (frame),
        .busy      (busy),
        .done      (done)
    );

    lcd_spi_shifter #(
        .CLK_DIV (`LCD_CLK_DIV)
    ) u_shift (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .frame (frame),
        .sdo   (sdo),
        .sclk  (sclk),
        .cs_n  (cs_n),
        .busy  (busy),
        .done  (done)
    );

endmodule

// ==== design/spi_pkg.sv ====
package spi_pkg;

    // One serial frame, sent MSB first
    typedef struct packed {
        logic       rs;    // 0 instruction, 1 character
        logic       rw;    // Always 0, write only
        logic [7:0] data;
    } spi_frame_t;

    typedef enum logic [2:0] {
        SPI_IDLE   = 3'd0,
        SPI_LEAD   = 3'd1, // cs_n low before first sclk
        SPI_SHIFT  = 3'd2,
        SPI_TRAIL  = 3'd3, // cs_n low after last sclk
        SPI_FINISH = 3'd4
    } spi_state_t;

endpackage
